/* verilog/lane_capture_pkg.sv */
package lane_capture_pkg;

	//////////////////////////////////////////////////
	// Receiver lanes
	//////////////////////////////////////////////////

	localparam int LANES = 4;
	localparam int LANE_W = 16;

	typedef logic [LANE_W-1:0] lane_word_t;

	//////////////////////////////////////////////////
	// Register port
	//////////////////////////////////////////////////

	localparam int REG_W = 32;
	localparam int ADDR_W = 4;

	typedef logic [REG_W-1:0] reg_data_t;
	typedef logic [ADDR_W-1:0] reg_addr_t;

	// Address map, lane n at base + n
	localparam reg_addr_t ADDR_STATUS_BASE = 4'd0;
	localparam reg_addr_t ADDR_DATA_BASE = 4'd4;
	localparam reg_addr_t ADDR_VERSION = 4'd8;

	localparam reg_data_t VERSION = 32'h4C43_0102;

	// Fill count field of a status word
	localparam int CNT_W = 16;

endpackage

/* verilog/lane_unpack.sv */
`timescale 1ns/1ps

module lane_unpack (
	input  logic                                                       CLK125,
	input  logic                                                       arst_n_i,
	input  logic [lane_capture_pkg::LANES*lane_capture_pkg::LANE_W-1:0] gtp_data_i,
	input  logic [lane_capture_pkg::LANES-1:0]                          gtp_kchar_i,
	output lane_capture_pkg::lane_word_t lane_dat_o [lane_capture_pkg::LANES],
	output logic [lane_capture_pkg::LANES-1:0]                          lane_vld_o
);
	import lane_capture_pkg::*;

	// Commas never count as data
	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			lane_vld_o <= '0;
		end else begin
			lane_vld_o <= ~gtp_kchar_i;
		end
	end

	// Lane 0 sits in the low bits of the receiver bus
	always_ff @(posedge CLK125) begin
		for (int n = 0; n < LANES; n++) begin
			lane_dat_o[n] <= gtp_data_i[n*LANE_W +: LANE_W];
		end
	end

endmodule

/* verilog/lane_fifo.sv */
`timescale 1ns/1ps

module lane_fifo #(
	parameter int FIFO_ABITS = 12
) (
	input  logic                         CLK125,
	input  logic                         arst_n_i,
	input  lane_capture_pkg::lane_word_t wr_dat_i,
	input  logic                         wr_stb_i,
	input  logic                         pop_i,
	input  logic                         ovf_clr_i,
	output lane_capture_pkg::lane_word_t head_o,
	output logic [FIFO_ABITS:0]          count_o,
	output logic                         ovf_o,
	output logic                         ovf_evt_o
);
	import lane_capture_pkg::*;

	localparam int DEPTH = 2 ** FIFO_ABITS;

	lane_word_t            mem [DEPTH];
	logic [FIFO_ABITS-1:0] wr_ptr;
	logic [FIFO_ABITS-1:0] rd_ptr;
	logic                  full;
	logic                  wr_ok;
	logic                  drop;

	// Count reaches DEPTH only with its top bit set
	assign full = count_o[FIFO_ABITS];
	assign wr_ok = wr_stb_i & ~full;
	assign drop = wr_stb_i & full;

	// Head word is always visible, pop only advances
	assign head_o = mem[rd_ptr];

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wr_dat_i;
		end
	end

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// Caller never pops an empty FIFO
			if (pop_i) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			count_o <= '0;
		end else begin
			case ({wr_ok, pop_i})
				2'b10:   count_o <= count_o + 1'b1;
				2'b01:   count_o <= count_o - 1'b1;
				default: count_o <= count_o;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Overflow
	//////////////////////////////////////////////////

	// One pulse per dropped word
	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ovf_evt_o <= 1'b0;
		end else begin
			ovf_evt_o <= drop;
		end
	end

	// Sticky flag, a new drop wins over a clear
	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ovf_o <= 1'b0;
		end else if (drop) begin
			ovf_o <= 1'b1;
		end else if (ovf_clr_i) begin
			ovf_o <= 1'b0;
		end
	end

endmodule

/* verilog/status_regs.sv */
`timescale 1ns/1ps

module status_regs #(
	parameter int FIFO_ABITS = 12
) (
	input  logic                                 CLK125,
	input  logic                                 arst_n_i,
	input  logic                                 rd_stb_i,
	input  logic                                 wr_stb_i,
	input  lane_capture_pkg::reg_addr_t          addr_i,
	output lane_capture_pkg::reg_data_t          rd_data_o,
	output logic                                 ack_o,
	input  logic [FIFO_ABITS:0]                  count_i [lane_capture_pkg::LANES],
	input  logic [lane_capture_pkg::LANES-1:0]   ovf_i,
	input  lane_capture_pkg::lane_word_t         head_i [lane_capture_pkg::LANES],
	output logic [lane_capture_pkg::LANES-1:0]   pop_o,
	output logic [lane_capture_pkg::LANES-1:0]   ovf_clr_o
);
	import lane_capture_pkg::*;

	reg_data_t rd_word;

	//////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////

	always_comb begin
		rd_word = '0;
		pop_o = '0;
		ovf_clr_o = '0;
		for (int n = 0; n < LANES; n++) begin
			// Status: overflow on top, count in the low half
			if (addr_i == reg_addr_t'(ADDR_STATUS_BASE + n)) begin
				rd_word[REG_W-1] = ovf_i[n];
				rd_word[CNT_W-1:0] = CNT_W'(count_i[n]);
				ovf_clr_o[n] = wr_stb_i;
			end
			// Data: empty lane reads as zero and keeps its pointers
			if (addr_i == reg_addr_t'(ADDR_DATA_BASE + n)) begin
				if (count_i[n] != '0) begin
					rd_word = reg_data_t'(head_i[n]);
					pop_o[n] = rd_stb_i;
				end
			end
		end
		if (addr_i == ADDR_VERSION) begin
			rd_word = VERSION;
		end
	end

	//////////////////////////////////////////////////
	// Read result and acknowledge
	//////////////////////////////////////////////////

	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= rd_stb_i | wr_stb_i;
		end
	end

	// Held until the next read
	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_data_o <= '0;
		end else if (rd_stb_i) begin
			rd_data_o <= rd_word;
		end
	end

endmodule

/* verilog/led_stretch.sv */
`timescale 1ns/1ps

module led_stretch #(
	parameter int LED_HOLD = 12500000
) (
	input  logic CLK125,
	input  logic arst_n_i,
	input  logic evt_i,
	output logic led_o
);

	localparam int HOLD_BITS = $clog2(LED_HOLD + 1);

	logic [HOLD_BITS-1:0] hold_cnt;

	// Every new event restarts the on-time
	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hold_cnt <= '0;
		end else if (evt_i) begin
			hold_cnt <= HOLD_BITS'(LED_HOLD);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign led_o = (hold_cnt != '0);

endmodule

/* verilog/lane_capture_top.sv */
`timescale 1ns/1ps

module lane_capture_top #(
	parameter int FIFO_ABITS = 12,
	parameter int LED_HOLD = 12500000
) (
	input  logic                                                       CLK125,
	input  logic                                                       arst_n_i,
	input  logic [lane_capture_pkg::LANES*lane_capture_pkg::LANE_W-1:0] gtp_data_i,
	input  logic [lane_capture_pkg::LANES-1:0]                          gtp_kchar_i,
	input  logic                                                       rd_stb_i,
	input  logic                                                       wr_stb_i,
	input  lane_capture_pkg::reg_addr_t                                 addr_i,
	output lane_capture_pkg::reg_data_t                                 rd_data_o,
	output logic                                                       ack_o,
	output logic [lane_capture_pkg::LANES-1:0]                          led_o
);
	import lane_capture_pkg::*;

	lane_word_t          lane_dat [LANES];
	logic [LANES-1:0]    lane_vld;
	logic [FIFO_ABITS:0] fifo_count [LANES];
	lane_word_t          fifo_head [LANES];
	logic [LANES-1:0]    fifo_ovf;
	logic [LANES-1:0]    fifo_ovf_evt;
	logic [LANES-1:0]    fifo_pop;
	logic [LANES-1:0]    fifo_ovf_clr;

	//////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////

	lane_unpack i_lane_unpack (
		.CLK125      (CLK125),
		.arst_n_i    (arst_n_i),
		.gtp_data_i  (gtp_data_i),
		.gtp_kchar_i (gtp_kchar_i),
		.lane_dat_o  (lane_dat),
		.lane_vld_o  (lane_vld)
	);

	//////////////////////////////////////////////////
	// Per-lane FIFO and overflow LED
	//////////////////////////////////////////////////

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		lane_fifo #(
			.FIFO_ABITS (FIFO_ABITS)
		) i_lane_fifo (
			.CLK125    (CLK125),
			.arst_n_i  (arst_n_i),
			.wr_dat_i  (lane_dat[i]),
			.wr_stb_i  (lane_vld[i]),
			.pop_i     (fifo_pop[i]),
			.ovf_clr_i (fifo_ovf_clr[i]),
			.head_o    (fifo_head[i]),
			.count_o   (fifo_count[i]),
			.ovf_o     (fifo_ovf[i]),
			.ovf_evt_o (fifo_ovf_evt[i])
		);

		led_stretch #(
			.LED_HOLD (LED_HOLD)
		) i_led_stretch (
			.CLK125   (CLK125),
			.arst_n_i (arst_n_i),
			.evt_i    (fifo_ovf_evt[i]),
			.led_o    (led_o[i])
		);
	end

	//////////////////////////////////////////////////
	// Host register port
	//////////////////////////////////////////////////

	status_regs #(
		.FIFO_ABITS (FIFO_ABITS)
	) i_status_regs (
		.CLK125    (CLK125),
		.arst_n_i  (arst_n_i),
		.rd_stb_i  (rd_stb_i),
		.wr_stb_i  (wr_stb_i),
		.addr_i    (addr_i),
		.rd_data_o (rd_data_o),
		.ack_o     (ack_o),
		.count_i   (fifo_count),
		.ovf_i     (fifo_ovf),
		.head_i    (fifo_head),
		.pop_o     (fifo_pop),
		.ovf_clr_o (fifo_ovf_clr)
	);

endmodule

/* verification/tb_lane_capture.sv */
`timescale 1ns/1ps

module tb_lane_capture;
	import lane_capture_pkg::*;

	localparam int FIFO_ABITS = 4;
	localparam int LED_HOLD = 20;
	localparam int DEPTH = 2 ** FIFO_ABITS;
	// Test sequence is a few hundred cycles long
	localparam int MAX_CYCLES = 3000;

	logic                      CLK125 = 1'b0;
	logic                      arst_n_i;
	logic [LANES*LANE_W-1:0]   gtp_data_i;
	logic [LANES-1:0]          gtp_kchar_i;
	logic                      rd_stb_i;
	logic                      wr_stb_i;
	reg_addr_t                 addr_i;
	reg_data_t                 rd_data_o;
	logic                      ack_o;
	logic [LANES-1:0]          led_o;

	// Reference model with one queue per lane
	lane_word_t       model_q [LANES][$];
	logic [LANES-1:0] model_ovf;

	int seed;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_cnt = 0;

	always #50 CLK125 = ~CLK125;

	lane_capture_top #(
		.FIFO_ABITS (FIFO_ABITS),
		.LED_HOLD   (LED_HOLD)
	) i_lane_capture_top (
		.CLK125      (CLK125),
		.arst_n_i    (arst_n_i),
		.gtp_data_i  (gtp_data_i),
		.gtp_kchar_i (gtp_kchar_i),
		.rd_stb_i    (rd_stb_i),
		.wr_stb_i    (wr_stb_i),
		.addr_i      (addr_i),
		.rd_data_o   (rd_data_o),
		.ack_o       (ack_o),
		.led_o       (led_o)
	);

	//////////////////////////////////////////////////
	// Register port handshake
	//////////////////////////////////////////////////

	assert property (@(posedge CLK125) disable iff (!arst_n_i)
		(rd_stb_i || wr_stb_i) |=> ack_o)
	else begin
		$display("** Error at %0t ns: ack_o missing after a strobe", $time);
		errors++;
	end

	assert property (@(posedge CLK125) disable iff (!arst_n_i)
		!(rd_stb_i || wr_stb_i) |=> !ack_o)
	else begin
		$display("** Error at %0t ns: ack_o without a strobe", $time);
		errors++;
	end

	// Run limit
	always @(posedge CLK125) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check_val(input string what, input reg_data_t got, input reg_data_t exp);
		assert (got === exp) else begin
			$display("** Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// One receiver cycle and the model update for the non-comma lanes
	task automatic drive_cycle(input logic [LANES*LANE_W-1:0] data, input logic [LANES-1:0] kchar);
		@(posedge CLK125);
		gtp_data_i <= data;
		gtp_kchar_i <= kchar;
		for (int n = 0; n < LANES; n++) begin
			if (!kchar[n]) begin
				if (model_q[n].size() < DEPTH) begin
					model_q[n].push_back(data[n*LANE_W +: LANE_W]);
				end else begin
					model_ovf[n] = 1'b1;
				end
			end
		end
	endtask

	task automatic drive_idle();
		drive_cycle({$random(seed), $random(seed)}, '1);
	endtask

	task automatic drive_word(input int lane, input lane_word_t word);
		logic [LANES*LANE_W-1:0] data;
		data = {$random(seed), $random(seed)};
		data[lane*LANE_W +: LANE_W] = word;
		drive_cycle(data, ~(LANES'(1) << lane));
	endtask

	// Covers the two-cycle input pipeline
	task automatic settle();
		repeat (3) drive_idle();
	endtask

	task automatic wait_ack(input string what);
		int waited;
		waited = 0;
		@(negedge CLK125);
		while (!ack_o && waited < 4) begin
			@(negedge CLK125);
			waited++;
		end
		if (!ack_o) begin
			$display("No acknowledge for the %s at %0t ns", what, $time);
			errors++;
		end
	endtask

	task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
		@(posedge CLK125);
		rd_stb_i <= 1'b1;
		addr_i <= addr;
		@(posedge CLK125);
		rd_stb_i <= 1'b0;
		wait_ack("register read");
		data = rd_data_o;
	endtask

	task automatic reg_write(input reg_addr_t addr);
		@(posedge CLK125);
		wr_stb_i <= 1'b1;
		addr_i <= addr;
		@(posedge CLK125);
		wr_stb_i <= 1'b0;
		wait_ack("register write");
	endtask

	task automatic status_check(input int lane);
		reg_data_t got;
		reg_data_t exp;
		exp = {model_ovf[lane], 15'b0, CNT_W'(model_q[lane].size())};
		reg_read(reg_addr_t'(ADDR_STATUS_BASE + lane), got);
		check_val($sformatf("status of lane %0d", lane), got, exp);
	endtask

	// Empty lane reads back as zero
	task automatic pop_check(input int lane);
		reg_data_t got;
		reg_data_t exp;
		exp = '0;
		if (model_q[lane].size() > 0) begin
			exp = reg_data_t'(model_q[lane].pop_front());
		end
		reg_read(reg_addr_t'(ADDR_DATA_BASE + lane), got);
		check_val($sformatf("data of lane %0d", lane), got, exp);
	endtask

	task automatic test_done(input string name, input int err_start);
		tests_run++;
		if (errors > err_start) begin
			tests_failed++;
			$display("Test %-12s failed, %0d errors", name, errors - err_start);
		end else begin
			$display("Test %-12s passed", name);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int err_start;
		int rise_at;
		int on_cycles;
		reg_data_t got;
		logic [LANES*LANE_W-1:0] data;
		logic [LANES-1:0] kchar;

		seed = 32'h3823;
		model_ovf = '0;
		arst_n_i = 1'b0;
		gtp_data_i = '0;
		gtp_kchar_i = '1;
		rd_stb_i = 1'b0;
		wr_stb_i = 1'b0;
		addr_i = '0;
		repeat (3) @(posedge CLK125);
		arst_n_i <= 1'b1;
		@(negedge CLK125);

		// Reset values
		err_start = errors;
		check_val("led_o after reset", reg_data_t'(led_o), '0);
		check_val("ack_o after reset", reg_data_t'(ack_o), '0);
		check_val("rd_data_o after reset", rd_data_o, '0);
		for (int n = 0; n < LANES; n++) status_check(n);
		reg_read(ADDR_VERSION, got);
		check_val("version", got, VERSION);
		test_done("reset", err_start);

		// Random words and commas on all lanes at once
		err_start = errors;
		for (int c = 0; c < 24; c++) begin
			data = {$random(seed), $random(seed)};
			kchar = LANES'($random(seed));
			for (int n = 0; n < LANES; n++) begin
				if (model_q[n].size() >= DEPTH) kchar[n] = 1'b1;
			end
			drive_cycle(data, kchar);
		end
		settle();
		for (int n = 0; n < LANES; n++) begin
			status_check(n);
			while (model_q[n].size() > 0) pop_check(n);
			status_check(n);
		end
		test_done("ordering", err_start);

		// Count goes down by one per pop
		err_start = errors;
		for (int i = 0; i < 10; i++) drive_word(1, lane_word_t'($random(seed)));
		settle();
		status_check(1);
		while (model_q[1].size() > 0) begin
			pop_check(1);
			status_check(1);
		end
		test_done("count", err_start);

		// Fill and drain lane 2 so its head slot holds an old nonzero word
		err_start = errors;
		for (int i = 0; i < DEPTH; i++) drive_word(2, ~lane_word_t'(i));
		settle();
		while (model_q[2].size() > 0) pop_check(2);
		pop_check(2);
		status_check(2);
		test_done("empty read", err_start);

		// Three words beyond a full FIFO
		err_start = errors;
		for (int i = 0; i < DEPTH + 3; i++) drive_word(3, lane_word_t'($random(seed)));
		settle();
		status_check(3);
		while (model_q[3].size() > 0) pop_check(3);
		status_check(3);
		reg_write(reg_addr_t'(ADDR_STATUS_BASE + 3));
		model_ovf[3] = 1'b0;
		status_check(3);
		test_done("overflow", err_start);

		// LED on lane 0 starting from all LEDs dark
		err_start = errors;
		for (int i = 0; i < LED_HOLD + 10 && led_o != '0; i++) begin
			drive_idle();
			@(negedge CLK125);
		end
		assert (led_o == '0) else begin
			$display("LEDs still lit from the previous test at %0t ns", $time);
			errors++;
		end
		for (int i = 0; i < DEPTH; i++) drive_word(0, lane_word_t'($random(seed)));
		settle();
		drive_word(0, lane_word_t'($random(seed)));
		rise_at = -1;
		on_cycles = 0;
		for (int c = 1; c <= LED_HOLD + 10; c++) begin
			drive_idle();
			@(negedge CLK125);
			assert ((led_o & ~(LANES'(1))) == '0) else begin
				$display("** Error at %0t ns: led_o %b, other lanes lit", $time, led_o);
				errors++;
			end
			if (led_o[0]) begin
				if (rise_at < 0) rise_at = c;
				on_cycles++;
			end else if (rise_at >= 0) begin
				break;
			end
		end
		// Two pipeline cycles before the overflow event
		assert (rise_at >= 0 && rise_at <= 5) else begin
			$display("LED of lane 0 did not light in time after the overflow");
			errors++;
		end
		assert (on_cycles >= LED_HOLD && on_cycles <= LED_HOLD + 3 && !led_o[0]) else begin
			$display("** Error at %0t ns: LED on for %0d cycles", $time, on_cycles);
			errors++;
		end
		while (model_q[0].size() > 0) pop_check(0);
		reg_write(reg_addr_t'(ADDR_STATUS_BASE + 0));
		model_ovf[0] = 1'b0;
		status_check(0);
		test_done("led", err_start);

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* flist.f */
verilog/lane_capture_pkg.sv
verilog/lane_unpack.sv
verilog/lane_fifo.sv
verilog/status_regs.sv
verilog/led_stretch.sv
verilog/lane_capture_top.sv
verification/tb_lane_capture.sv

/* Makefile */
# Verilator simulation of the lane capture design
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_lane_capture
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build and run the simulation, result taken from $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
